//--- hw/rvf_pkg.sv
// RV32 fetch unit shared definitions
// Widths, reset PC, opcode enums and the structs passed between the blocks
`default_nettype none

package rvf_pkg;

  //////////////////////////////
  // Sizes
  localparam int XLEN             = 32;
  localparam int PARCEL_W         = 16;
  localparam int PARCELS_PER_WORD = 2;
  localparam logic [XLEN-1:0] PC_INIT = 32'h200;
  localparam int QUEUE_DEPTH      = 8;                                 // In parcels
  localparam int REQ_THRESHOLD    = QUEUE_DEPTH - 2*PARCELS_PER_WORD;  // Room for two words
  localparam int LEVEL_W          = $clog2(QUEUE_DEPTH + 1);

  localparam logic [31:0] NOP_INSN = 32'h0000_0013;  // addi x0,x0,0
  localparam logic [31:0] WFI_INSN = 32'h1050_0073;

  //////////////////////////////
  // Opcodes
  // Compressed class is {quadrant, funct3}, quadrant 11 is never compressed
  typedef enum logic [4:0] {
    C_ADDI4SPN = 5'b00_000,
    C_LW       = 5'b00_010,
    C_SW       = 5'b00_110,
    C_ADDI     = 5'b01_000,  // Also C.NOP
    C_JAL      = 5'b01_001,
    C_LI       = 5'b01_010,
    C_J        = 5'b01_101,
    C_BEQZ     = 5'b01_110,
    C_BNEZ     = 5'b01_111,
    C_CR       = 5'b10_100,  // C.MV C.JR C.ADD C.JALR C.EBREAK
    C_OTHER    = 5'b11_111
  } rvc_op_e;

  typedef enum logic [6:0] {
    LOAD   = 7'b000_0011,
    OP_IMM = 7'b001_0011,
    STORE  = 7'b010_0011,
    OP     = 7'b011_0011,
    BRANCH = 7'b110_0011,
    JALR   = 7'b110_0111,
    JAL    = 7'b110_1111,
    SYSTEM = 7'b111_0011
  } rv_opcode_e;

  //////////////////////////////
  // Structs
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            error;  // Bus error on this word
    logic            valid;
  } imem_rsp_t;

  typedef struct packed {
    logic [1:0][PARCEL_W-1:0] parcel;  // [0] is the oldest
    logic [1:0]               valid;
    logic [1:0]               error;
  } parcel_pair_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic            compressed;
    logic            illegal;
    logic            access_fault;
  } fetch_insn_t;

endpackage

`default_nettype wire

//--- hw/fetch_addr_gen.sv
// Fetch address generator
// Sequential word requests, one in flight, redirect kill and drop-low tracking
`timescale 1ns/1ps
`default_nettype none

module fetch_addr_gen (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           redirect_i,
  input  logic [rvf_pkg::XLEN-1:0]       redirect_pc_i,
  input  logic [rvf_pkg::LEVEL_W-1:0]    queue_level_i,
  input  logic                           imem_ack_i,
  input  rvf_pkg::imem_rsp_t             imem_rsp_i,
  output logic                           imem_req_o,
  output logic [rvf_pkg::XLEN-1:0]       imem_adr_o,
  output logic                           imem_flush_o,
  output logic                           wr_o,
  output rvf_pkg::imem_rsp_t             wr_word_o,
  output logic                           wr_drop_low_o
);

  logic outstanding_q;  // Transfer made last cycle
  logic kill_q;         // Its response belongs to the old path
  logic drop_q;         // Next written word starts at the high parcel
  logic xfer;

  assign xfer         = imem_req_o & imem_ack_i;
  assign imem_req_o   = (!outstanding_q || imem_rsp_i.valid) &&
                        (queue_level_i <= rvf_pkg::REQ_THRESHOLD);
  assign imem_flush_o = redirect_i;

  // Response filter
  assign wr_o          = imem_rsp_i.valid & ~kill_q & ~redirect_i;
  assign wr_word_o     = imem_rsp_i;
  assign wr_drop_low_o = drop_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      imem_adr_o    <= rvf_pkg::PC_INIT;
      outstanding_q <= 1'b0;
      kill_q        <= 1'b0;
      drop_q        <= 1'b0;
    end
    else
    begin
      outstanding_q <= xfer;
      kill_q        <= redirect_i & xfer;
      if (redirect_i)
      begin
        imem_adr_o <= {redirect_pc_i[rvf_pkg::XLEN-1:2], 2'b00};  // Word aligned
        drop_q     <= redirect_pc_i[1];
      end
      else
      begin
        if (xfer) imem_adr_o <= imem_adr_o + (rvf_pkg::XLEN / 8);
        if (wr_o) drop_q <= 1'b0;
      end
    end
  end

  // Memory answers only the cycle after a transfer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_rsp_i.valid |-> outstanding_q);

endmodule

`default_nettype wire

//--- hw/parcel_queue.sv
// Parcel queue
// Shift buffer of 16-bit parcels with error bits, one word in and
// up to two parcels out per cycle
`timescale 1ns/1ps
`default_nettype none

module parcel_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        wr_i,
  input  rvf_pkg::imem_rsp_t          wr_word_i,
  input  logic                        wr_drop_low_i,
  input  logic [1:0]                  rd_count_i,
  output rvf_pkg::parcel_pair_t       pair_o,
  output logic [rvf_pkg::LEVEL_W-1:0] level_o
);

  logic [rvf_pkg::QUEUE_DEPTH-1:0][rvf_pkg::PARCEL_W-1:0]      buf_q;
  logic [rvf_pkg::QUEUE_DEPTH-1:0][rvf_pkg::PARCEL_W-1:0]      buf_d;
  logic [rvf_pkg::QUEUE_DEPTH-1:0]                             err_q;
  logic [rvf_pkg::QUEUE_DEPTH-1:0]                             err_d;
  logic [rvf_pkg::PARCELS_PER_WORD-1:0][rvf_pkg::PARCEL_W-1:0] word_parcels;
  logic [rvf_pkg::LEVEL_W-1:0]                                 level_q;
  logic [rvf_pkg::LEVEL_W-1:0]                                 kept;   // Left after the read
  logic [1:0]                                                  wr_n;

  assign word_parcels = wr_word_i.rdata;
  assign wr_n = wr_i ? (wr_drop_low_i ? 2'd1 : 2'd2) : 2'd0;
  assign kept = level_q - {{(rvf_pkg::LEVEL_W-2){1'b0}}, rd_count_i};

  //////////////////////////////
  // Next buffer contents
  always_comb
  begin : next_buf
    int src;
    int pos;
    buf_d = buf_q;
    err_d = err_q;
    // Drop the consumed parcels off the bottom
    for (int i = 0; i < rvf_pkg::QUEUE_DEPTH; i++)
    begin
      src = i + int'(rd_count_i);
      if (src < rvf_pkg::QUEUE_DEPTH)
      begin
        buf_d[i] = buf_q[src];
        err_d[i] = err_q[src];
      end
    end
    // Append behind the remaining parcels
    pos = int'(kept);
    if (wr_i && pos < rvf_pkg::QUEUE_DEPTH)
    begin
      buf_d[pos] = wr_drop_low_i ? word_parcels[1] : word_parcels[0];
      err_d[pos] = wr_word_i.error;
    end
    if (wr_i && !wr_drop_low_i && pos + 1 < rvf_pkg::QUEUE_DEPTH)
    begin
      buf_d[pos+1] = word_parcels[1];
      err_d[pos+1] = wr_word_i.error;
    end
  end

  always_ff @(posedge clk_i)
  begin
    buf_q <= buf_d;
    err_q <= err_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      level_q <= '0;
    else if (flush_i)
      level_q <= '0;  // Redirect empties the queue
    else
      level_q <= kept + {{(rvf_pkg::LEVEL_W-2){1'b0}}, wr_n};
  end

  //////////////////////////////
  // Outputs
  assign pair_o.parcel = buf_q[1:0];
  assign pair_o.valid  = {level_q >= 2, level_q != 0};
  assign pair_o.error  = err_q[1:0];
  assign level_o       = level_q;

  // Request throttle in the address generator keeps room for every word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !flush_i |-> ({1'b0, kept} + wr_n) <= rvf_pkg::QUEUE_DEPTH);

  // Expander never takes parcels that are not there
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_count_i <= level_q);

endmodule

`default_nettype wire

//--- hw/rvc_expander.sv
// RVC expander
// Length decode, compressed-to-RV32 expansion, illegal check, WFI as NOP
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
  input  rvf_pkg::parcel_pair_t pair_i,
  input  logic                  stall_i,
  output logic [1:0]            rd_count_o,
  output rvf_pkg::fetch_insn_t  insn_o,
  output logic                  insn_ok_o
);

  logic [15:0]      c;
  logic             is16;
  rvf_pkg::rvc_op_e op;
  logic [31:0]      rvc_insn;
  logic             rvc_ill;
  logic [4:0]       rd, rs2, rs1p, low_p;
  logic [11:0]      imm_ci, imm_ciw, imm_cl;
  logic [19:0]      j_field;
  logic [6:0]       b_hi;
  logic [4:0]       b_lo;

  assign c    = pair_i.parcel[0];
  assign is16 = c[1:0] != 2'b11;

  // Whole instruction present
  assign insn_ok_o  = is16 ? pair_i.valid[0] : &pair_i.valid;
  assign rd_count_o = (insn_ok_o && !stall_i) ? (is16 ? 2'd1 : 2'd2) : 2'd0;

  //////////////////////////////
  // Field extraction
  assign rd      = c[11:7];
  assign rs2     = c[6:2];
  assign rs1p    = {2'b01, c[9:7]};
  assign low_p   = {2'b01, c[4:2]};  // rd' or rs2'
  assign imm_ci  = {{7{c[12]}}, c[6:2]};
  assign imm_ciw = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
  assign imm_cl  = {5'b00000, c[5], c[12:10], c[6], 2'b00};
  assign j_field = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], c[12], {8{c[12]}}};
  assign b_hi    = {c[12], c[12], c[12], c[12], c[6:5], c[2]};
  assign b_lo    = {c[11:10], c[4:3], c[12]};

  always_comb
  begin
    case ({c[1:0], c[15:13]})
      rvf_pkg::C_ADDI4SPN, rvf_pkg::C_LW, rvf_pkg::C_SW, rvf_pkg::C_ADDI,
      rvf_pkg::C_JAL, rvf_pkg::C_LI, rvf_pkg::C_J, rvf_pkg::C_BEQZ,
      rvf_pkg::C_BNEZ, rvf_pkg::C_CR: op = rvf_pkg::rvc_op_e'({c[1:0], c[15:13]});
      default:                        op = rvf_pkg::C_OTHER;
    endcase
  end

  //////////////////////////////
  // Expansion
  always_comb
  begin
    rvc_insn = {16'h0000, c};  // Illegal ones pass zero-extended
    rvc_ill  = 1'b0;
    case (op)
      rvf_pkg::C_ADDI4SPN:
        if (imm_ciw == 12'd0) rvc_ill = 1'b1;  // Covers the all-zero parcel
        else rvc_insn = {imm_ciw, 5'd2, 3'b000, low_p, rvf_pkg::OP_IMM};
      rvf_pkg::C_LW:   rvc_insn = {imm_cl, rs1p, 3'b010, low_p, rvf_pkg::LOAD};
      rvf_pkg::C_SW:   rvc_insn = {imm_cl[11:5], low_p, rs1p, 3'b010, imm_cl[4:0], rvf_pkg::STORE};
      rvf_pkg::C_ADDI: rvc_insn = {imm_ci, rd, 3'b000, rd, rvf_pkg::OP_IMM};
      rvf_pkg::C_LI:   rvc_insn = {imm_ci, 5'd0, 3'b000, rd, rvf_pkg::OP_IMM};
      rvf_pkg::C_JAL:  rvc_insn = {j_field, 5'd1, rvf_pkg::JAL};  // Link to x1
      rvf_pkg::C_J:    rvc_insn = {j_field, 5'd0, rvf_pkg::JAL};
      rvf_pkg::C_BEQZ: rvc_insn = {b_hi, 5'd0, rs1p, 3'b000, b_lo, rvf_pkg::BRANCH};
      rvf_pkg::C_BNEZ: rvc_insn = {b_hi, 5'd0, rs1p, 3'b001, b_lo, rvf_pkg::BRANCH};
      rvf_pkg::C_CR:
        if (rs2 != 5'd0)
          rvc_insn = {7'b0000000, rs2, c[12] ? rd : 5'd0, 3'b000, rd, rvf_pkg::OP};  // ADD or MV
        else if (rd != 5'd0)
          rvc_insn = {12'h000, rd, 3'b000, {4'b0000, c[12]}, rvf_pkg::JALR};  // JALR or JR
        else if (c[12])
          rvc_insn = {12'h001, 13'h0000, rvf_pkg::SYSTEM};  // EBREAK
        else
          rvc_ill = 1'b1;  // C.JR with x0 is reserved
      default: rvc_ill = 1'b1;
    endcase
  end

  always_comb
  begin
    insn_o              = '0;
    insn_o.compressed   = is16;
    insn_o.illegal      = is16 & rvc_ill;
    insn_o.access_fault = is16 ? pair_i.error[0] : |pair_i.error;
    if (is16)
      insn_o.instr = rvc_insn;
    else if (pair_i.parcel == rvf_pkg::WFI_INSN)
      insn_o.instr = rvf_pkg::NOP_INSN;  // WFI runs as NOP
    else
      insn_o.instr = pair_i.parcel;
  end

endmodule

`default_nettype wire

//--- hw/fetch_output_stage.sv
// Fetch output stage
// Tracks the instruction PC and registers the instruction towards decode
`timescale 1ns/1ps
`default_nettype none

module fetch_output_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     redirect_i,
  input  logic [rvf_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                     stall_i,
  input  rvf_pkg::fetch_insn_t     insn_i,
  input  logic                     insn_ok_i,
  output rvf_pkg::fetch_insn_t     insn_o,
  output logic                     insn_valid_o
);

  logic [rvf_pkg::XLEN-1:0] pc_q;   // PC of the instruction at the queue head
  logic [rvf_pkg::XLEN-1:0] pc_inc;
  rvf_pkg::fetch_insn_t     stamped;
  logic                     take;

  assign take   = insn_ok_i & ~stall_i;
  // 2 for compressed, else 4
  assign pc_inc = {{(rvf_pkg::XLEN-3){1'b0}}, ~insn_i.compressed, insn_i.compressed, 1'b0};

  always_comb
  begin
    stamped    = insn_i;
    stamped.pc = pc_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pc_q <= rvf_pkg::PC_INIT;
    else if (redirect_i)
      pc_q <= {redirect_pc_i[rvf_pkg::XLEN-1:1], 1'b0};
    else if (take)
      pc_q <= pc_q + pc_inc;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      insn_valid_o <= 1'b0;
    else if (redirect_i)
      insn_valid_o <= 1'b0;  // Old path is gone
    else if (!stall_i)
      insn_valid_o <= insn_ok_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i) insn_o <= stamped;
  end

  // Queue keeps offering an instruction that decode held back
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i && insn_ok_i && !redirect_i |=> insn_ok_i && $stable(insn_i));

endmodule

`default_nettype wire

//--- hw/riscv_fetch.sv
// RV32 instruction fetch unit with RVC support
// Address generator, parcel queue, expander and output register
`timescale 1ns/1ps
`default_nettype none

module riscv_fetch (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  output logic                     imem_req_o,
  output logic [rvf_pkg::XLEN-1:0] imem_adr_o,
  input  logic                     imem_ack_i,
  input  rvf_pkg::imem_rsp_t       imem_rsp_i,
  output logic                     imem_flush_o,
  input  logic                     redirect_i,
  input  logic [rvf_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                     stall_i,
  output rvf_pkg::fetch_insn_t     insn_o,
  output logic                     insn_valid_o
);

  logic [rvf_pkg::LEVEL_W-1:0] queue_level;
  logic                        wr;
  rvf_pkg::imem_rsp_t          wr_word;
  logic                        wr_drop_low;
  rvf_pkg::parcel_pair_t       pair;
  logic [1:0]                  rd_count;
  rvf_pkg::fetch_insn_t        exp_insn;   // PC still zero here
  logic                        exp_ok;

  fetch_addr_gen u_addr_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .queue_level_i (queue_level),
    .imem_ack_i    (imem_ack_i),
    .imem_rsp_i    (imem_rsp_i),
    .imem_req_o    (imem_req_o),
    .imem_adr_o    (imem_adr_o),
    .imem_flush_o  (imem_flush_o),
    .wr_o          (wr),
    .wr_word_o     (wr_word),
    .wr_drop_low_o (wr_drop_low)
  );

  parcel_queue u_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (imem_flush_o),
    .wr_i          (wr),
    .wr_word_i     (wr_word),
    .wr_drop_low_i (wr_drop_low),
    .rd_count_i    (rd_count),
    .pair_o        (pair),
    .level_o       (queue_level)
  );

  rvc_expander u_expander (
    .pair_i     (pair),
    .stall_i    (stall_i),
    .rd_count_o (rd_count),
    .insn_o     (exp_insn),
    .insn_ok_o  (exp_ok)
  );

  fetch_output_stage u_out (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .insn_i        (exp_insn),
    .insn_ok_i     (exp_ok),
    .insn_o        (insn_o),
    .insn_valid_o  (insn_valid_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_riscv_fetch.sv
// Testbench for the RV32 fetch unit
// Memory model with random ack, random decode stall, redirect driver
// and an in-order checker against the expected instruction stream
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_fetch;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       imem_req_o;
  logic [31:0]                imem_adr_o;
  logic                       imem_ack_i;
  rvf_pkg::imem_rsp_t         imem_rsp_i;
  logic                       imem_flush_o;
  logic                       redirect_i;
  logic [31:0]                redirect_pc_i;
  logic                       stall_i;
  rvf_pkg::fetch_insn_t       insn_o;
  logic                       insn_valid_o;

  logic [31:0] mem [0:255];
  logic        mem_err [0:255];
  logic [31:0] exp_test [0:63];
  logic [31:0] exp_pc [0:63];
  logic [31:0] exp_instr [0:63];
  logic [2:0]  exp_flags [0:63];  // compressed, illegal, access_fault
  int          n_exp;
  int          redir_after;
  logic [31:0] redir_target;
  logic        redir_done;
  int          n_checked;
  int          errors;
  int          cur_test;
  int          test_checks;
  int          test_errs;
  logic        run;
  logic        xfer_q;
  logic [31:0] xfer_adr_q;
  logic        after_redir_q;
  integer      seed;
  string       test_names [1:6];

  riscv_fetch u_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic close_test();
    $display("test %0d (%s): %0d checked, %0d errors", cur_test,
             test_names[cur_test], test_checks, test_errs);
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic load_stimulus();
    integer fd;
    integer r;
    logic [31:0] kind, a, b, c, d, e, f;
    logic [8*256-1:0] skip;
    fd = $fopen("testbench/fetch_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        r = $fscanf(fd, "%h", kind);
        if (r != 1)
          r = $fgets(skip, fd);  // Comment line
        else if (kind == 0)
        begin
          r = $fscanf(fd, "%h %h %h", a, b, c);
          mem[a[9:2]]     = b;
          mem_err[a[9:2]] = c[0];
        end
        else if (kind == 1)
        begin
          r = $fscanf(fd, "%h %h", a, b);
          redir_after  = int'(a);
          redir_target = b;
        end
        else
        begin
          r = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
          exp_test[n_exp]  = a;
          exp_pc[n_exp]    = b;
          exp_instr[n_exp] = c;
          exp_flags[n_exp] = {d[0], e[0], f[0]};
          n_exp++;
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////
  // Memory model and drivers
  always @(negedge clk_i)
  begin
    if (run)
    begin
      imem_rsp_i = '0;
      if (xfer_q)
      begin
        imem_rsp_i.valid = 1'b1;
        imem_rsp_i.rdata = mem[xfer_adr_q[9:2]];
        imem_rsp_i.error = mem_err[xfer_adr_q[9:2]];
      end
      imem_ack_i = ($random(seed) & 3) != 0;
      stall_i    = ($random(seed) & 3) == 0;
      redirect_i = 1'b0;
      if (!redir_done && redir_after >= 0 && n_checked == redir_after)
      begin
        redirect_i    = 1'b1;
        redirect_pc_i = redir_target;
        stall_i       = 1'b1;  // No take in the redirect cycle
        redir_done    = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Checker
  always @(posedge clk_i)
  begin
    if (run)
    begin
      xfer_q        <= imem_req_o & imem_ack_i;
      xfer_adr_q    <= imem_adr_o;
      after_redir_q <= redirect_i;
      // Flush only in the redirect cycle
      compare_field("imem_flush_o", {31'd0, imem_flush_o}, {31'd0, redirect_i});
      if (after_redir_q)
        compare_field("insn_valid_o after redirect", {31'd0, insn_valid_o}, 32'd0);
      if (insn_valid_o && !stall_i)
      begin
        if (int'(exp_test[n_checked]) != cur_test)
        begin
          close_test();
          cur_test = int'(exp_test[n_checked]);
        end
        compare_field("insn_o.pc", insn_o.pc, exp_pc[n_checked]);
        compare_field("insn_o.instr", insn_o.instr, exp_instr[n_checked]);
        compare_field("insn_o.compressed", {31'd0, insn_o.compressed},
                      {31'd0, exp_flags[n_checked][2]});
        compare_field("insn_o.illegal", {31'd0, insn_o.illegal},
                      {31'd0, exp_flags[n_checked][1]});
        compare_field("insn_o.access_fault", {31'd0, insn_o.access_fault},
                      {31'd0, exp_flags[n_checked][0]});
        test_checks++;
        n_checked++;
      end
    end
  end

  // Watchdog, 200 cycles per expected instruction
  initial
  begin
    wait (run);
    repeat (n_exp * 200) @(posedge clk_i);
    $display("Timeout with %0d of %0d instructions accepted", n_checked, n_exp);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    rst_ni        = 1'b0;
    imem_ack_i    = 1'b0;
    imem_rsp_i    = '0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b0;
    seed          = 32'hee56_1fd5;
    n_exp         = 0;
    redir_after   = -1;
    redir_target  = '0;
    redir_done    = 1'b0;
    n_checked     = 0;
    errors        = 0;
    cur_test      = 1;
    test_checks   = 0;
    test_errs     = 0;
    run           = 1'b0;
    xfer_q        = 1'b0;
    xfer_adr_q    = '0;
    after_redir_q = 1'b0;
    test_names[1] = "sequential 32-bit";
    test_names[2] = "mixed 16/32-bit";
    test_names[3] = "illegal compressed";
    test_names[4] = "redirect";
    test_names[5] = "random stall and ack";
    test_names[6] = "access fault and WFI";
    for (int i = 0; i < 256; i++)
    begin
      mem[i]     = 32'h0000_0013 | (i << 20);  // addi x0,x0,index
      mem_err[i] = 1'b0;
    end
    load_stimulus();

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    compare_field("insn_valid_o", {31'd0, insn_valid_o}, 32'd0);
    compare_field("imem_flush_o", {31'd0, imem_flush_o}, 32'd0);
    compare_field("imem_adr_o", imem_adr_o, rvf_pkg::PC_INIT);
    compare_field("imem_req_o", {31'd0, imem_req_o}, 32'd1);  // Empty queue asks for a word

    if (n_exp == 0)
    begin
      $display("No expected instructions in the stimulus file");
      errors++;
    end
    else
    begin
      @(posedge clk_i);
      run = 1'b1;
      wait (n_checked == n_exp);
    end
    close_test();
    $display("%0d instructions checked, %0d errors", n_checked, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- riscv_fetch.f
hw/rvf_pkg.sv
hw/fetch_addr_gen.sv
hw/parcel_queue.sv
hw/rvc_expander.sv
hw/fetch_output_stage.sv
hw/riscv_fetch.sv
testbench/tb_riscv_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f riscv_fetch.f \
  --top-module tb_riscv_fetch -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_riscv_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
exit 1

//--- testbench/fetch_stimulus.txt
# 0 word_addr data error | 1 after_n_accepted target_pc
# 2 test pc instr compressed illegal access_fault
0 200 00100093 0
0 204 00200113 0
0 208 002081b3 0
0 20c 157d4515 0
0 210 52b70800 0
0 214 40441234 0
0 218 85aac404 0
0 21c 000195aa 0
0 220 3ff5a021 0
0 224 fcfdc019 0
0 228 92828082 0
0 22c 00009002 0
0 230 00014082 0
0 234 00400213 0
0 238 00400213 0
0 23c 00400213 0
0 240 461dffff 0
0 244 00d00693 0
0 248 07b38736 0
0 24c 000100d7 0
0 250 10500073 1
0 254 0001157d 0
1 16 242
2 1 200 00100093 0 0 0
2 1 204 00200113 0 0 0
2 1 208 002081b3 0 0 0
2 2 20c 00500513 1 0 0
2 2 20e fff50513 1 0 0
2 2 210 01010413 1 0 0
2 2 212 123452b7 0 0 0
2 2 216 00442483 1 0 0
2 2 218 00942423 1 0 0
2 2 21a 00a005b3 1 0 0
2 2 21c 00a585b3 1 0 0
2 2 21e 00000013 1 0 0
2 2 220 0080006f 1 0 0
2 2 222 ffdff0ef 1 0 0
2 2 224 00040363 1 0 0
2 2 226 fe049fe3 1 0 0
2 2 228 00008067 1 0 0
2 2 22a 000280e7 1 0 0
2 2 22c 00100073 1 0 0
2 3 22e 00000000 1 1 0
2 3 230 00004082 1 1 0
2 3 232 00000013 1 0 0
2 4 242 00700613 1 0 0
2 5 244 00d00693 0 0 0
2 5 248 00d00733 1 0 0
2 5 24a 00d707b3 0 0 0
2 5 24e 00000013 1 0 0
2 6 250 00000013 0 0 1
2 6 254 fff50513 1 0 0
2 6 256 00000013 1 0 0
